//--- all.f
+incdir+rtl
+incdir+tb
rtl/udp_pkg.sv
rtl/udp_rx.sv
rtl/udp_sock.sv
rtl/udp_tx.sv
rtl/udp_echo_top.sv
tb/udp_echo_tb.sv

//--- rtl/udp_cfg.svh
`ifndef UDP_CFG_SVH
`define UDP_CFG_SVH

// sockets bound to consecutive ports
`define UDP_NUM_SOCK 4

`define UDP_BASE_PORT 1000 // port of socket 0

// payload bytes one socket can hold
`define UDP_SOCK_DEPTH 32

`define UDP_HDR_LEN 8

// IPv4 protocol number for UDP
`define UDP_PROTO 8'd17

`endif

//--- rtl/udp_echo_top.sv
`default_nettype none
`include "udp_cfg.svh"

module udp_echo_top (
  input  logic              clk,
  input  logic              fsm_rst,
  input  udp_pkg::ip_strm_t ip_rx,
  input  udp_pkg::ip_meta_t ip_rx_meta,
  output udp_pkg::ip_strm_t ip_tx,
  output udp_pkg::ip_meta_t ip_tx_meta,
  output logic              ip_tx_rdy,
  input  logic              ip_tx_req
);

  udp_pkg::ip_strm_t pl;   // payload broadcast to all sockets
  udp_pkg::udp_meta_t meta;
  logic [`UDP_NUM_SOCK-1:0] full;
  logic [`UDP_NUM_SOCK-1:0] release_sock;
  udp_pkg::udp_meta_t sock_meta [`UDP_NUM_SOCK];
  udp_pkg::byte_t rd_dat [`UDP_NUM_SOCK];
  udp_pkg::len_t rd_addr;

  udp_rx udp_rx_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .ip_rx      (ip_rx),
    .ip_rx_meta (ip_rx_meta),
    .pl         (pl),
    .meta       (meta)
  );

  for (genvar i = 0; i < `UDP_NUM_SOCK; i++) begin : g_sock
    udp_sock #(
      .SOCK_IDX (i)
    ) udp_sock_i (
      .clk          (clk),
      .fsm_rst      (fsm_rst),
      .pl           (pl),
      .meta         (meta),
      .full         (full[i]),
      .sock_meta    (sock_meta[i]),
      .rd_addr      (rd_addr),
      .rd_dat       (rd_dat[i]),
      .release_sock (release_sock[i])
    );
  end

  udp_tx udp_tx_i (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .full         (full),
    .sock_meta    (sock_meta),
    .rd_addr      (rd_addr),
    .rd_dat       (rd_dat),
    .release_sock (release_sock),
    .ip_tx        (ip_tx),
    .ip_tx_meta   (ip_tx_meta),
    .ip_tx_rdy    (ip_tx_rdy),
    .ip_tx_req    (ip_tx_req)
  );

endmodule

`default_nettype wire

//--- rtl/udp_pkg.sv
`default_nettype none
`include "udp_cfg.svh"

package udp_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] port_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] len_t;
  typedef logic [$clog2(`UDP_NUM_SOCK)-1:0] sock_idx_t;

  // byte stream, also used for the UDP payload and the transmit side
  typedef struct packed {
    byte_t dat;
    logic  val;
    logic  sof;
    logic  eof;
    logic  err;
  } ip_strm_t;

  typedef struct packed {
    ip_addr_t src_ip;
    ip_addr_t dst_ip;
    byte_t    proto;
    len_t     payload_len; // IPv4 payload, UDP header included
  } ip_meta_t;

  typedef struct packed {
    ip_addr_t peer_ip; // sender of the datagram
    port_t    src_port;
    port_t    dst_port;
    len_t     len;     // UDP length field
  } udp_meta_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HDR,
    RX_DATA,
    RX_SKIP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_OFFER,
    TX_HDR,
    TX_DATA
  } tx_state_t;

endpackage

`default_nettype wire

//--- rtl/udp_rx.sv
`default_nettype none
`include "udp_cfg.svh"

module udp_rx (
  input  logic               clk,
  input  logic               fsm_rst,
  input  udp_pkg::ip_strm_t  ip_rx,
  input  udp_pkg::ip_meta_t  ip_rx_meta,
  output udp_pkg::ip_strm_t  pl,
  output udp_pkg::udp_meta_t meta
);

  udp_pkg::rx_state_t state;
  udp_pkg::byte_t [`UDP_HDR_LEN-2:0] hdr; // header bytes, oldest on top
  udp_pkg::len_t byte_cnt;                // index of the current byte
  udp_pkg::len_t byte_nxt;
  logic err_seen;
  logic len_bad;
  logic hdr_last;
  logic fwd;

  assign byte_nxt = byte_cnt + 16'd1;
  assign hdr_last = (byte_cnt == udp_pkg::len_t'(`UDP_HDR_LEN - 1));
  assign fwd      = (state == udp_pkg::RX_DATA) && ip_rx.val;

  // total so far against the UDP length field
  assign len_bad = (byte_nxt != meta.len);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= udp_pkg::RX_IDLE;
      byte_cnt <= '0;
      err_seen <= 1'b0;
    end else begin
      if (ip_rx.val) begin
        byte_cnt <= ip_rx.sof ? 16'd1 : byte_nxt;
      end
      case (state)
        udp_pkg::RX_IDLE: begin
          if (ip_rx.val && ip_rx.sof && !ip_rx.eof) begin
            err_seen <= ip_rx.err;
            state    <= (ip_rx_meta.proto == `UDP_PROTO) ? udp_pkg::RX_HDR : udp_pkg::RX_SKIP;
          end
        end
        udp_pkg::RX_HDR: begin
          if (ip_rx.val) begin
            err_seen <= err_seen | ip_rx.err;
            if (ip_rx.eof) begin
              state <= udp_pkg::RX_IDLE; // runt, nothing forwarded
            end else if (hdr_last) begin
              state <= udp_pkg::RX_DATA;
            end
          end
        end
        udp_pkg::RX_DATA: begin
          if (ip_rx.val) begin
            err_seen <= err_seen | ip_rx.err;
            if (ip_rx.eof) begin
              state <= udp_pkg::RX_IDLE;
            end
          end
        end
        udp_pkg::RX_SKIP: begin
          if (ip_rx.val && ip_rx.eof) begin
            state <= udp_pkg::RX_IDLE;
          end
        end
        default: state <= udp_pkg::RX_IDLE;
      endcase
    end
  end

  // header shift and latch on its last byte
  always_ff @(posedge clk) begin
    if (ip_rx.val) begin
      hdr <= {hdr[`UDP_HDR_LEN-3:0], ip_rx.dat};
    end
    if (state == udp_pkg::RX_HDR && ip_rx.val && hdr_last) begin
      meta.peer_ip  <= ip_rx_meta.src_ip;
      meta.src_port <= {hdr[6], hdr[5]};
      meta.dst_port <= {hdr[4], hdr[3]};
      meta.len      <= {hdr[2], hdr[1]}; // checksum not kept
    end
  end

  always_ff @(posedge clk) begin
    pl.dat <= ip_rx.dat;
    if (fsm_rst) begin
      pl.val <= 1'b0;
      pl.sof <= 1'b0;
      pl.eof <= 1'b0;
      pl.err <= 1'b0;
    end else begin
      pl.val <= fwd;
      pl.sof <= fwd && (byte_cnt == udp_pkg::len_t'(`UDP_HDR_LEN));
      pl.eof <= fwd && ip_rx.eof;
      pl.err <= fwd && ip_rx.eof && (err_seen || ip_rx.err || len_bad);
    end
  end

endmodule

`default_nettype wire

//--- rtl/udp_sock.sv
`default_nettype none
`include "udp_cfg.svh"

module udp_sock #(
  parameter int SOCK_IDX = 0
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  udp_pkg::ip_strm_t  pl,
  input  udp_pkg::udp_meta_t meta,
  output logic               full,
  output udp_pkg::udp_meta_t sock_meta,
  input  udp_pkg::len_t      rd_addr,
  output udp_pkg::byte_t     rd_dat,
  input  logic               release_sock
);

  localparam int AW = $clog2(`UDP_SOCK_DEPTH);
  localparam udp_pkg::port_t PORT = udp_pkg::port_t'(`UDP_BASE_PORT + SOCK_IDX);
  localparam udp_pkg::len_t MAX_LEN = udp_pkg::len_t'(`UDP_SOCK_DEPTH + `UDP_HDR_LEN);

  udp_pkg::byte_t mem [`UDP_SOCK_DEPTH];
  udp_pkg::len_t wr_ptr; // next free byte
  udp_pkg::len_t wr_addr;
  logic taking;          // datagram in progress is ours
  logic hit;
  logic wr_en;

  // UDP length counts the header too
  assign hit = (meta.dst_port == PORT) && !full && (meta.len <= MAX_LEN);

  assign wr_addr = pl.sof ? '0 : wr_ptr;
  assign wr_en   = pl.val && (pl.sof ? hit : taking);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      taking <= 1'b0;
      full   <= 1'b0;
      wr_ptr <= '0;
    end else begin
      if (pl.val && pl.sof) begin
        taking <= hit && !pl.eof;
      end else if (pl.val && pl.eof) begin
        taking <= 1'b0;
      end
      if (wr_en) begin
        wr_ptr <= wr_addr + 16'd1;
      end
      if (release_sock) begin
        full <= 1'b0;
      end else if (wr_en && pl.eof && !pl.err) begin
        full <= 1'b1; // clean datagram committed
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr < udp_pkg::len_t'(`UDP_SOCK_DEPTH))) begin
      mem[wr_addr[AW-1:0]] <= pl.dat;
    end
    if (pl.val && pl.sof && hit) begin
      sock_meta <= meta;
    end
  end

  assign rd_dat = mem[rd_addr[AW-1:0]];

endmodule

`default_nettype wire

//--- rtl/udp_tx.sv
`default_nettype none
`include "udp_cfg.svh"

module udp_tx (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic [`UDP_NUM_SOCK-1:0]  full,
  input  udp_pkg::udp_meta_t        sock_meta [`UDP_NUM_SOCK],
  output udp_pkg::len_t             rd_addr,
  input  udp_pkg::byte_t            rd_dat [`UDP_NUM_SOCK],
  output logic [`UDP_NUM_SOCK-1:0]  release_sock,
  output udp_pkg::ip_strm_t         ip_tx,
  output udp_pkg::ip_meta_t         ip_tx_meta,
  output logic                      ip_tx_rdy,
  input  logic                      ip_tx_req
);

  udp_pkg::tx_state_t state;
  udp_pkg::sock_idx_t rr_ptr; // first socket to look at
  udp_pkg::sock_idx_t cur;
  udp_pkg::sock_idx_t pick;
  udp_pkg::byte_t [`UDP_HDR_LEN-1:0] hdr_q;
  udp_pkg::len_t cnt;         // bytes already sent
  udp_pkg::len_t udp_len;
  logic [`UDP_NUM_SOCK-1:0] avail;
  logic found;
  logic send;
  logic last;

  // a socket being released still shows full for one cycle
  assign avail = full & ~release_sock;

  always_comb begin
    found = 1'b0;
    pick  = rr_ptr;
    for (int i = 0; i < `UDP_NUM_SOCK; i++) begin
      if (!found && avail[udp_pkg::sock_idx_t'(rr_ptr + i)]) begin
        found = 1'b1;
        pick  = udp_pkg::sock_idx_t'(rr_ptr + i);
      end
    end
  end

  assign send = (state == udp_pkg::TX_OFFER && ip_tx_rdy && ip_tx_req) ||
                (state == udp_pkg::TX_HDR) || (state == udp_pkg::TX_DATA);
  assign last = (cnt == udp_len - 16'd1);
  assign rd_addr = cnt - udp_pkg::len_t'(`UDP_HDR_LEN);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state        <= udp_pkg::TX_IDLE;
      rr_ptr       <= '0;
      cur          <= '0;
      cnt          <= '0;
      ip_tx_rdy    <= 1'b0;
      ip_tx.val    <= 1'b0;
      ip_tx.sof    <= 1'b0;
      ip_tx.eof    <= 1'b0;
      ip_tx.err    <= 1'b0;
      release_sock <= '0;
    end else begin
      ip_tx.sof    <= 1'b0;
      ip_tx.eof    <= 1'b0;
      release_sock <= '0;
      if (send) begin
        ip_tx.dat <= (state == udp_pkg::TX_DATA) ? rd_dat[cur] : hdr_q[`UDP_HDR_LEN-1];
      end
      case (state)
        udp_pkg::TX_IDLE: begin
          ip_tx.val <= 1'b0;
          if (found) begin
            cur   <= pick;
            state <= udp_pkg::TX_OFFER;
          end
        end
        udp_pkg::TX_OFFER: begin
          ip_tx_rdy <= 1'b1;
          if (ip_tx_rdy && ip_tx_req) begin
            ip_tx_rdy <= 1'b0;
            ip_tx.val <= 1'b1;
            ip_tx.sof <= 1'b1;
            cnt       <= 16'd1;
            state     <= udp_pkg::TX_HDR;
          end
        end
        udp_pkg::TX_HDR: begin
          cnt <= cnt + 16'd1;
          if (cnt == udp_pkg::len_t'(`UDP_HDR_LEN - 1)) begin
            state <= udp_pkg::TX_DATA;
          end
        end
        udp_pkg::TX_DATA: begin
          cnt <= cnt + 16'd1;
          if (last) begin
            ip_tx.eof         <= 1'b1;
            release_sock[cur] <= 1'b1;
            rr_ptr            <= udp_pkg::sock_idx_t'(cur + 1'b1);
            state             <= udp_pkg::TX_IDLE;
          end
        end
        default: state <= udp_pkg::TX_IDLE;
      endcase
    end
  end

  // reply header with the ports swapped
  always_ff @(posedge clk) begin
    if (state == udp_pkg::TX_IDLE && found) begin
      hdr_q <= {sock_meta[pick].dst_port, sock_meta[pick].src_port,
                sock_meta[pick].len, 16'h0000};
      udp_len                <= sock_meta[pick].len; // already counts the header
      ip_tx_meta.src_ip      <= '0; // filled in by the IPv4 layer
      ip_tx_meta.dst_ip      <= sock_meta[pick].peer_ip;
      ip_tx_meta.proto       <= `UDP_PROTO;
      ip_tx_meta.payload_len <= sock_meta[pick].len;
    end
    if (send) begin
      hdr_q <= {hdr_q[`UDP_HDR_LEN-2:0], 8'h00};
    end
  end

endmodule

`default_nettype wire

//--- tb/udp_echo_tests.svh
`ifndef UDP_ECHO_TESTS_SVH
`define UDP_ECHO_TESTS_SVH

// sends header plus n_pl random bytes; len_extra skews the UDP length field
task automatic send_datagram(input udp_pkg::ip_addr_t src_ip, input udp_pkg::byte_t proto,
                             input udp_pkg::port_t sport, input udp_pkg::port_t dport,
                             input int n_pl, input int len_extra, input int slot);
  logic [63:0] hdr;
  int total;
  int i;
  total = n_pl + `UDP_HDR_LEN;
  hdr = {sport, dport, udp_pkg::len_t'(total + len_extra), 16'h0000};
  for (i = 0; i < n_pl; i++) begin
    exp_pl[slot][i] = udp_pkg::byte_t'($urandom);
  end
  for (i = 0; i < total; i++) begin
    @(negedge clk);
    ip_rx.dat = (i < `UDP_HDR_LEN) ? hdr[63-8*i -: 8] : exp_pl[slot][i-`UDP_HDR_LEN];
    ip_rx.val = 1'b1;
    ip_rx.sof = (i == 0);
    ip_rx.eof = (i == total - 1);
    ip_rx.err = 1'b0;
    ip_rx_meta.src_ip = src_ip;
    ip_rx_meta.dst_ip = 32'h0a00_0002; // this host
    ip_rx_meta.proto = proto;
    ip_rx_meta.payload_len = udp_pkg::len_t'(total);
  end
  @(negedge clk);
  ip_rx = '0;
  ip_rx_meta = '0;
endtask

task automatic wait_replies(input string test, input int count, input int limit);
  int n;
  n = 0;
  while (rep_len.size() < count && n < limit) begin
    @(posedge clk);
    n++;
  end
  if (rep_len.size() < count) begin
    $display("ERROR %s: only %0d of %0d replies arrived within %0d cycles",
             test, rep_len.size(), count, limit);
    err_cnt++;
  end
endtask

task automatic expect_quiet(input string test, input int n_cyc);
  repeat (n_cyc) @(posedge clk);
  if (rep_len.size() != 0) report_mismatch(test, "extra replies", 0, rep_len.size());
  if (in_frame) begin
    $display("ERROR %s: a reply is still being sent", test);
    err_cnt++;
  end
  rep_len.delete();
  rep_dat.delete();
  rep_meta.delete();
endtask

task automatic check_reply(input string test, input int slot, input udp_pkg::ip_addr_t peer,
                           input udp_pkg::port_t sport, input udp_pkg::port_t dport,
                           input int n_pl);
  logic [63:0] hdr;
  udp_pkg::ip_meta_t m;
  udp_pkg::byte_t got;
  udp_pkg::byte_t want;
  int n;
  int i;
  if (rep_len.size() == 0) begin
    $display("ERROR %s: no reply left to check", test);
    err_cnt++;
  end else begin
    hdr = {dport, sport, udp_pkg::len_t'(n_pl + `UDP_HDR_LEN), 16'h0000}; // ports swapped
    n = rep_len.pop_front();
    m = rep_meta.pop_front();
    if (n != n_pl + `UDP_HDR_LEN) report_mismatch(test, "reply bytes", n_pl + `UDP_HDR_LEN, n);
    if (m.dst_ip !== peer) report_mismatch(test, "dst_ip", peer, m.dst_ip);
    if (m.proto !== 8'd17) report_mismatch(test, "proto", 17, m.proto);
    if (m.payload_len !== n_pl + `UDP_HDR_LEN) begin
      report_mismatch(test, "payload_len", n_pl + `UDP_HDR_LEN, m.payload_len);
    end
    for (i = 0; i < n; i++) begin
      got = rep_dat.pop_front();
      want = (i < `UDP_HDR_LEN) ? hdr[63-8*i -: 8] : exp_pl[slot][i-`UDP_HDR_LEN];
      if (i < n_pl + `UDP_HDR_LEN && got !== want) begin
        report_mismatch(test, $sformatf("byte %0d", i), want, got);
      end
    end
  end
endtask

task automatic test_echo();
  int e;
  e = err_cnt;
  send_datagram(32'h0a00_0001, 8'd17, 16'd5000, 16'd1000, 10, 0, 0);
  wait_replies("echo", 1, 200);
  check_reply("echo", 0, 32'h0a00_0001, 16'd5000, 16'd1000, 10);
  expect_quiet("echo", 40);
  finish_test("echo", e);
endtask

task automatic test_proto_filter();
  int e;
  e = err_cnt;
  send_datagram(32'h0a00_0001, 8'd6, 16'd5000, 16'd1000, 10, 0, 0); // TCP
  expect_quiet("proto_filter", 100);
  finish_test("proto_filter", e);
endtask

task automatic test_unbound_port();
  int e;
  e = err_cnt;
  send_datagram(32'h0a00_0001, 8'd17, 16'd5000, 16'd1010, 10, 0, 0);
  expect_quiet("unbound_port", 100);
  finish_test("unbound_port", e);
endtask

task automatic test_length_error();
  int e;
  e = err_cnt;
  send_datagram(32'h0a00_0003, 8'd17, 16'd6000, 16'd1000, 12, 4, 0); // 4 bytes short
  send_datagram(32'h0a00_0003, 8'd17, 16'd6000, 16'd1000, 6, 0, 1);
  wait_replies("length_error", 1, 200);
  check_reply("length_error", 1, 32'h0a00_0003, 16'd6000, 16'd1000, 6);
  expect_quiet("length_error", 60);
  finish_test("length_error", e);
endtask

task automatic test_round_robin();
  int e;
  e = err_cnt;
  @(negedge clk);
  ip_tx_req = 1'b0;
  // socket 3 holds the transmitter while sockets 2 and 1 fill behind it
  send_datagram(32'h0a00_0005, 8'd17, 16'd7003, 16'd1003, 5, 0, 3);
  send_datagram(32'h0a00_0005, 8'd17, 16'd7002, 16'd1002, 6, 0, 2);
  send_datagram(32'h0a00_0005, 8'd17, 16'd7001, 16'd1001, 7, 0, 1);
  repeat (10) @(negedge clk);
  if (ip_tx_rdy !== 1'b1) report_mismatch("round_robin", "ip_tx_rdy", 1, ip_tx_rdy);
  if (rep_len.size() != 0) report_mismatch("round_robin", "early replies", 0, rep_len.size());
  ip_tx_req = 1'b1;
  wait_replies("round_robin", 3, 300);
  check_reply("round_robin", 3, 32'h0a00_0005, 16'd7003, 16'd1003, 5);
  check_reply("round_robin", 1, 32'h0a00_0005, 16'd7001, 16'd1001, 7); // wraps past 0
  check_reply("round_robin", 2, 32'h0a00_0005, 16'd7002, 16'd1002, 6);
  expect_quiet("round_robin", 40);
  finish_test("round_robin", e);
endtask

task automatic test_oversize();
  int e;
  e = err_cnt;
  send_datagram(32'h0a00_0007, 8'd17, 16'd8000, 16'd1000, 40, 0, 0);
  send_datagram(32'h0a00_0007, 8'd17, 16'd8000, 16'd1000, `UDP_SOCK_DEPTH, 0, 1);
  wait_replies("oversize", 1, 300);
  check_reply("oversize", 1, 32'h0a00_0007, 16'd8000, 16'd1000, `UDP_SOCK_DEPTH);
  expect_quiet("oversize", 60);
  finish_test("oversize", e);
endtask

`endif

//--- tb/udp_echo_tb.sv
`default_nettype none
`include "udp_cfg.svh"

module udp_echo_tb;

  localparam int TIMEOUT_CYCLES = 3000; // six tests, about 400 cycles each at most
  localparam int BUF_LEN = 64;

  logic clk = 1'b0;
  logic fsm_rst;
  udp_pkg::ip_strm_t ip_rx;
  udp_pkg::ip_meta_t ip_rx_meta;
  udp_pkg::ip_strm_t ip_tx;
  udp_pkg::ip_meta_t ip_tx_meta;
  logic ip_tx_rdy;
  logic ip_tx_req;

  udp_pkg::byte_t rep_dat[$];      // bytes of all replies, back to back
  int rep_len[$];
  udp_pkg::ip_meta_t rep_meta[$];
  udp_pkg::byte_t exp_pl [`UDP_NUM_SOCK][BUF_LEN]; // sent payloads by buffer slot
  logic in_frame = 1'b0;
  int cur_len = 0;
  int cycles = 0;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int rnd_seed;

  always #20 clk = ~clk;

  udp_echo_top udp_echo_top_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .ip_rx      (ip_rx),
    .ip_rx_meta (ip_rx_meta),
    .ip_tx      (ip_tx),
    .ip_tx_meta (ip_tx_meta),
    .ip_tx_rdy  (ip_tx_rdy),
    .ip_tx_req  (ip_tx_req)
  );

  // reply collector, sampled on the falling edge
  always @(negedge clk) begin
    if (!fsm_rst && ip_tx.val) begin
      if (ip_tx.sof) begin
        if (in_frame) begin
          $display("ERROR: reply started before the previous one ended");
          err_cnt++;
        end
        in_frame = 1'b1;
        cur_len = 0;
        rep_meta.push_back(ip_tx_meta); // held stable while sending
      end else if (!in_frame) begin
        $display("ERROR: reply byte seen without a start of frame");
        err_cnt++;
      end
      if (ip_tx.err) begin
        $display("ERROR: err strobe set on a reply byte");
        err_cnt++;
      end
      rep_dat.push_back(ip_tx.dat);
      cur_len++;
      if (ip_tx.eof) begin
        rep_len.push_back(cur_len);
        in_frame = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h", test, what, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, err_cnt - err_before);
    end
  endtask

  `include "udp_echo_tests.svh"

  initial begin
    rnd_seed = 1;
    void'($urandom(rnd_seed));
    fsm_rst = 1'b1;
    ip_rx = '0;
    ip_rx_meta = '0;
    ip_tx_req = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    ip_tx_req = 1'b1;
    test_echo();
    test_proto_filter();
    test_unbound_port();
    test_length_error();
    test_round_robin();
    test_oversize();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
